//--- src/ctl_pkg.sv
package ctl_pkg;

	// Widths fixed by RV64, Sv39 and the base encoding
	typedef logic [31:0] instr_t;
	typedef logic [63:0] xlen_t;
	typedef logic [15:0] asid_t;
	typedef logic [26:0] vpn_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// Sv39 VPN field inside a virtual address
	localparam int VPN_LSB = 12;
	localparam int VPN_MSB = 38;

	// Major opcodes
	localparam opcode_t OPC_BRANCH   = 7'b1100011;
	localparam opcode_t OPC_LOAD     = 7'b0000011;
	localparam opcode_t OPC_STORE    = 7'b0100011;
	localparam opcode_t OPC_MISC_MEM = 7'b0001111;
	localparam opcode_t OPC_SYSTEM   = 7'b1110011;

	// Branch funct3
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Load funct3
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LD  = 3'b011;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_LWU = 3'b110;

	// Store funct3
	localparam funct3_t F3_SB = 3'b000;
	localparam funct3_t F3_SH = 3'b001;
	localparam funct3_t F3_SW = 3'b010;
	localparam funct3_t F3_SD = 3'b011;

	// Fences
	localparam funct3_t F3_FENCE_I    = 3'b001;
	localparam funct3_t F3_PRIV       = 3'b000;
	localparam funct7_t F7_SFENCE_VMA = 7'b0001001;

	// Exception causes, mcause encoding
	typedef enum logic [3:0] {
		E_I_ADDR_MISALIGNED  = 4'd0,
		E_I_ACCESS_FAULT     = 4'd1,
		E_ILLEGAL_INSTR      = 4'd2,
		E_LD_ADDR_MISALIGNED = 4'd4,
		E_LD_ACCESS_FAULT    = 4'd5,
		E_ST_ADDR_MISALIGNED = 4'd6,
		E_ST_ACCESS_FAULT    = 4'd7,
		E_ENV_CALL_UMODE     = 4'd8,
		E_ENV_CALL_SMODE     = 4'd9,
		E_ENV_CALL_MMODE     = 4'd11,
		E_INSTR_PAGE_FAULT   = 4'd12,
		E_LD_PAGE_FAULT      = 4'd13,
		E_ST_PAGE_FAULT      = 4'd15
	} except_code_e;

	typedef enum logic [2:0] {
		BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} branch_e;

	typedef enum logic [2:0] {
		LS_BYTE, LS_BYTE_U, LS_HALF, LS_HALF_U, LS_WORD, LS_WORD_U, LS_DOUBLE
	} ldst_e;

	typedef enum logic [1:0] {
		TLB_NO_FLUSH, TLB_FLUSH_ALL, TLB_FLUSH_ASID, TLB_FLUSH_PAGE
	} tlb_flush_e;

	typedef enum logic {
		MS_IDLE, MS_SYNC
	} maint_state_e;

	typedef struct packed {
		branch_e branch;
		logic    branch_valid;
		ldst_e   ldst;
		logic    is_load;
		logic    is_store;
		logic    fence_i;
		logic    sfence_vma;
	} decode_t;

	typedef struct packed {
		logic instr_side;
		logic data_side;
		logic page_fault;
		logic illegal;
		logic ecall_sys;
	} except_class_t;

	typedef struct packed {
		logic abort;
		logic clr_l1tlb;
		logic clr_l2tlb;
		logic clr_dmshr;
	} maint_cmd_t;

	typedef struct packed {
		tlb_flush_e kind;
		asid_t      asid;
		vpn_t       vpn;
	} tlb_flush_t;

endpackage

//--- src/ctl_instr_decode.sv
`timescale 1ns/1ps

module ctl_instr_decode (
	input  ctl_pkg::instr_t  instr_i,
	output ctl_pkg::decode_t dec_o
);

	ctl_pkg::opcode_t opcode;
	ctl_pkg::funct3_t funct3;
	ctl_pkg::funct7_t funct7;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	always_comb begin
		// All-zero result for anything not recognised
		dec_o = '0;

		case (opcode)
			ctl_pkg::OPC_BRANCH: begin
				dec_o.branch_valid = 1'b1;
				case (funct3)
					ctl_pkg::F3_BEQ:  dec_o.branch = ctl_pkg::BR_BEQ;
					ctl_pkg::F3_BNE:  dec_o.branch = ctl_pkg::BR_BNE;
					ctl_pkg::F3_BLT:  dec_o.branch = ctl_pkg::BR_BLT;
					ctl_pkg::F3_BGE:  dec_o.branch = ctl_pkg::BR_BGE;
					ctl_pkg::F3_BLTU: dec_o.branch = ctl_pkg::BR_BLTU;
					ctl_pkg::F3_BGEU: dec_o.branch = ctl_pkg::BR_BGEU;
					// funct3 2 and 3 are reserved
					default:          dec_o.branch_valid = 1'b0;
				endcase
			end

			ctl_pkg::OPC_LOAD: begin
				dec_o.is_load = 1'b1;
				case (funct3)
					ctl_pkg::F3_LB:  dec_o.ldst = ctl_pkg::LS_BYTE;
					ctl_pkg::F3_LH:  dec_o.ldst = ctl_pkg::LS_HALF;
					ctl_pkg::F3_LW:  dec_o.ldst = ctl_pkg::LS_WORD;
					ctl_pkg::F3_LD:  dec_o.ldst = ctl_pkg::LS_DOUBLE;
					ctl_pkg::F3_LBU: dec_o.ldst = ctl_pkg::LS_BYTE_U;
					ctl_pkg::F3_LHU: dec_o.ldst = ctl_pkg::LS_HALF_U;
					ctl_pkg::F3_LWU: dec_o.ldst = ctl_pkg::LS_WORD_U;
					default:         dec_o.is_load = 1'b0;
				endcase
			end

			ctl_pkg::OPC_STORE: begin
				dec_o.is_store = 1'b1;
				case (funct3)
					ctl_pkg::F3_SB: dec_o.ldst = ctl_pkg::LS_BYTE;
					ctl_pkg::F3_SH: dec_o.ldst = ctl_pkg::LS_HALF;
					ctl_pkg::F3_SW: dec_o.ldst = ctl_pkg::LS_WORD;
					ctl_pkg::F3_SD: dec_o.ldst = ctl_pkg::LS_DOUBLE;
					// No unsigned stores
					default:        dec_o.is_store = 1'b0;
				endcase
			end

			ctl_pkg::OPC_MISC_MEM: begin
				// Plain FENCE is a no-op for this unit
				dec_o.fence_i = (funct3 == ctl_pkg::F3_FENCE_I);
			end

			ctl_pkg::OPC_SYSTEM: begin
				dec_o.sfence_vma = (funct3 == ctl_pkg::F3_PRIV) &&
					(funct7 == ctl_pkg::F7_SFENCE_VMA);
			end

			default: begin
				dec_o = '0;
			end
		endcase
	end

endmodule

//--- src/ctl_except_classify.sv
`timescale 1ns/1ps

module ctl_except_classify (
	input  ctl_pkg::except_code_e  except_code_i,
	output ctl_pkg::except_class_t class_o
);

	always_comb begin
		class_o = '0;

		case (except_code_i)
			// Fetch side
			ctl_pkg::E_I_ADDR_MISALIGNED,
			ctl_pkg::E_I_ACCESS_FAULT: begin
				class_o.instr_side = 1'b1;
			end
			ctl_pkg::E_INSTR_PAGE_FAULT: begin
				class_o.instr_side = 1'b1;
				class_o.page_fault = 1'b1;
			end

			// Load/store side
			ctl_pkg::E_LD_ADDR_MISALIGNED,
			ctl_pkg::E_LD_ACCESS_FAULT,
			ctl_pkg::E_ST_ADDR_MISALIGNED,
			ctl_pkg::E_ST_ACCESS_FAULT: begin
				class_o.data_side = 1'b1;
			end
			ctl_pkg::E_LD_PAGE_FAULT,
			ctl_pkg::E_ST_PAGE_FAULT: begin
				class_o.data_side  = 1'b1;
				class_o.page_fault = 1'b1;
			end

			ctl_pkg::E_ILLEGAL_INSTR: begin
				class_o.illegal = 1'b1;
			end

			// Only S and M mode calls need the cache sync
			ctl_pkg::E_ENV_CALL_SMODE,
			ctl_pkg::E_ENV_CALL_MMODE: begin
				class_o.ecall_sys = 1'b1;
			end

			// U mode calls and reserved codes
			default: begin
				class_o = '0;
			end
		endcase
	end

endmodule

//--- src/ctl_maint_fsm.sv
`timescale 1ns/1ps

module ctl_maint_fsm (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  ctl_pkg::decode_t       dec_i,
	input  logic                   instr_valid_i,
	input  ctl_pkg::except_class_t class_i,
	input  logic                   except_raised_i,
	input  ctl_pkg::xlen_t         except_addr_i,
	input  logic                   fetch_except_i,
	input  logic                   main_stall_i,
	input  ctl_pkg::asid_t         asid_i,
	input  logic                   l2c_done_i,
	output ctl_pkg::maint_cmd_t    cmd_o,
	output ctl_pkg::tlb_flush_t    tlb_flush_o,
	output logic                   flush_o,
	output logic                   stall_o,
	output logic                   synch_o
);

	ctl_pkg::maint_state_e state_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q          <= ctl_pkg::MS_IDLE;
			cmd_o            <= '0;
			tlb_flush_o.kind <= ctl_pkg::TLB_NO_FLUSH;
			tlb_flush_o.asid <= '0;
			tlb_flush_o.vpn  <= '0;
			flush_o          <= 1'b0;
			stall_o          <= 1'b0;
		end else begin
			// Commands are single-cycle pulses
			cmd_o            <= '0;
			tlb_flush_o.kind <= ctl_pkg::TLB_NO_FLUSH;
			tlb_flush_o.asid <= '0;
			tlb_flush_o.vpn  <= '0;
			flush_o          <= 1'b0;
			// Back-pressure only ever adds a stall
			stall_o          <= main_stall_i;

			case (state_q)
				ctl_pkg::MS_IDLE: begin
					if (except_raised_i) begin
						// Committed exception wins over everything
						flush_o           <= 1'b1;
						cmd_o.abort       <= class_i.illegal;
						cmd_o.clr_l1tlb   <= class_i.instr_side;
						cmd_o.clr_l2tlb   <= class_i.instr_side;
						cmd_o.clr_dmshr   <= class_i.data_side;
						if (class_i.page_fault) begin
							tlb_flush_o.kind <= ctl_pkg::TLB_FLUSH_PAGE;
							tlb_flush_o.vpn  <=
								except_addr_i[ctl_pkg::VPN_MSB:ctl_pkg::VPN_LSB];
						end else begin
							tlb_flush_o.kind <= ctl_pkg::TLB_FLUSH_ALL;
						end
						if (class_i.ecall_sys) begin
							state_q <= ctl_pkg::MS_SYNC;
							stall_o <= 1'b1;
						end
					end else if (fetch_except_i) begin
						flush_o          <= 1'b1;
						stall_o          <= 1'b1;
						tlb_flush_o.kind <= ctl_pkg::TLB_FLUSH_ASID;
						tlb_flush_o.asid <= asid_i;
					end else if (instr_valid_i && dec_i.fence_i) begin
						cmd_o.clr_l1tlb <= 1'b1;
						cmd_o.clr_l2tlb <= 1'b1;
					end else if (instr_valid_i && dec_i.sfence_vma) begin
						cmd_o.clr_l1tlb  <= 1'b1;
						cmd_o.clr_l2tlb  <= 1'b1;
						cmd_o.clr_dmshr  <= 1'b1;
						tlb_flush_o.kind <= ctl_pkg::TLB_FLUSH_ALL;
						state_q          <= ctl_pkg::MS_SYNC;
						stall_o          <= 1'b1;
					end
				end

				ctl_pkg::MS_SYNC: begin
					// Wait for L1-D to L2 write-back, other inputs ignored
					if (l2c_done_i) begin
						state_q <= ctl_pkg::MS_IDLE;
					end else begin
						stall_o <= 1'b1;
					end
				end
			endcase
		end
	end

	// Sync request follows the state register
	assign synch_o = (state_q == ctl_pkg::MS_SYNC);

	// Pipeline must be held for the whole sync
	a_synch_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		synch_o |-> stall_o);

	// Abort and clears come from disjoint exception classes
	a_abort_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cmd_o.abort |-> !(cmd_o.clr_l1tlb || cmd_o.clr_l2tlb || cmd_o.clr_dmshr));

endmodule

//--- src/ctl_unit_top.sv
`timescale 1ns/1ps

module ctl_unit_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	// Issue
	input  ctl_pkg::instr_t       instr_i,
	input  logic                  instr_valid_i,
	input  logic                  main_stall_i,
	input  logic                  fetch_except_i,
	// Commit
	input  logic                  except_raised_i,
	input  ctl_pkg::except_code_e except_code_i,
	input  ctl_pkg::xlen_t        except_addr_i,
	input  ctl_pkg::asid_t        asid_i,
	input  logic                  l2c_done_i,
	output ctl_pkg::decode_t      dec_o,
	output ctl_pkg::maint_cmd_t   cmd_o,
	output ctl_pkg::tlb_flush_t   tlb_flush_o,
	output logic                  flush_o,
	output logic                  stall_o,
	output logic                  synch_o
);

	ctl_pkg::except_class_t except_class;

	ctl_instr_decode i_ctl_instr_decode (
		.instr_i (instr_i),
		.dec_o   (dec_o)
	);

	ctl_except_classify i_ctl_except_classify (
		.except_code_i (except_code_i),
		.class_o       (except_class)
	);

	// Decode result also feeds the fence handling
	ctl_maint_fsm i_ctl_maint_fsm (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.dec_i           (dec_o),
		.instr_valid_i   (instr_valid_i),
		.class_i         (except_class),
		.except_raised_i (except_raised_i),
		.except_addr_i   (except_addr_i),
		.fetch_except_i  (fetch_except_i),
		.main_stall_i    (main_stall_i),
		.asid_i          (asid_i),
		.l2c_done_i      (l2c_done_i),
		.cmd_o           (cmd_o),
		.tlb_flush_o     (tlb_flush_o),
		.flush_o         (flush_o),
		.stall_o         (stall_o),
		.synch_o         (synch_o)
	);

endmodule

//--- testbench/tb_ctl_unit.sv
`timescale 1ns/1ps

module tb_ctl_unit;

	localparam int CYCLES       = 2000;
	localparam int RESET_CYCLES = 8;
	localparam int CLK_PERIOD   = 10;
	// Whole run plus some margin
	localparam int WATCHDOG_NS  = (RESET_CYCLES + CYCLES + 200) * CLK_PERIOD;

	logic                  clk;
	logic                  rst_n;
	ctl_pkg::instr_t       instr;
	logic                  instr_valid;
	logic                  main_stall;
	logic                  fetch_except;
	logic                  except_raised;
	ctl_pkg::except_code_e except_code;
	ctl_pkg::xlen_t        except_addr;
	ctl_pkg::asid_t        asid;
	logic                  l2c_done;

	ctl_pkg::decode_t    dec;
	ctl_pkg::maint_cmd_t cmd;
	ctl_pkg::tlb_flush_t tlb_flush;
	logic                flush;
	logic                stall;
	logic                synch;

	// Reference model state, current and next cycle
	ctl_pkg::maint_state_e m_state;
	ctl_pkg::maint_state_e nxt_state;
	ctl_pkg::maint_cmd_t   exp_cmd;
	ctl_pkg::maint_cmd_t   nxt_cmd;
	ctl_pkg::tlb_flush_t   exp_tlb;
	ctl_pkg::tlb_flush_t   nxt_tlb;
	logic                  exp_flush;
	logic                  nxt_flush;
	logic                  exp_stall;
	logic                  nxt_stall;

	integer seed = 32'hd1684ed5;
	int     errors;
	int     checks;
	bit     done_armed;
	int     done_cnt;

	ctl_unit_top i_ctl_unit_top (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.instr_i         (instr),
		.instr_valid_i   (instr_valid),
		.main_stall_i    (main_stall),
		.fetch_except_i  (fetch_except),
		.except_raised_i (except_raised),
		.except_code_i   (except_code),
		.except_addr_i   (except_addr),
		.asid_i          (asid),
		.l2c_done_i      (l2c_done),
		.dec_o           (dec),
		.cmd_o           (cmd),
		.tlb_flush_o     (tlb_flush),
		.flush_o         (flush),
		.stall_o         (stall),
		.synch_o         (synch)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Expected decode straight from the ISA tables
	function automatic ctl_pkg::decode_t expect_decode(input ctl_pkg::instr_t w);
		ctl_pkg::decode_t d;
		d = '0;
		if (w[6:0] == 7'b1100011) begin
			d.branch_valid = 1'b1;
			case (w[14:12])
				3'd0: d.branch = ctl_pkg::BR_BEQ;
				3'd1: d.branch = ctl_pkg::BR_BNE;
				3'd4: d.branch = ctl_pkg::BR_BLT;
				3'd5: d.branch = ctl_pkg::BR_BGE;
				3'd6: d.branch = ctl_pkg::BR_BLTU;
				3'd7: d.branch = ctl_pkg::BR_BGEU;
				default: d.branch_valid = 1'b0;
			endcase
		end else if (w[6:0] == 7'b0000011 && w[14:12] != 3'd7) begin
			d.is_load = 1'b1;
			case (w[14:12])
				3'd0: d.ldst = ctl_pkg::LS_BYTE;
				3'd1: d.ldst = ctl_pkg::LS_HALF;
				3'd2: d.ldst = ctl_pkg::LS_WORD;
				3'd3: d.ldst = ctl_pkg::LS_DOUBLE;
				3'd4: d.ldst = ctl_pkg::LS_BYTE_U;
				3'd5: d.ldst = ctl_pkg::LS_HALF_U;
				default: d.ldst = ctl_pkg::LS_WORD_U;
			endcase
		end else if (w[6:0] == 7'b0100011 && w[14] == 1'b0) begin
			d.is_store = 1'b1;
			case (w[13:12])
				2'd0: d.ldst = ctl_pkg::LS_BYTE;
				2'd1: d.ldst = ctl_pkg::LS_HALF;
				2'd2: d.ldst = ctl_pkg::LS_WORD;
				default: d.ldst = ctl_pkg::LS_DOUBLE;
			endcase
		end
		d.fence_i = (w[6:0] == 7'b0001111) && (w[14:12] == 3'd1);
		d.sfence_vma = (w[6:0] == 7'b1110011) && (w[14:12] == 3'd0) &&
			(w[31:25] == 7'b0001001);
		return d;
	endfunction

	// Exception classes by mcause value
	function automatic ctl_pkg::except_class_t classify_code(input logic [3:0] c);
		ctl_pkg::except_class_t k;
		k = '0;
		k.instr_side = (c == 4'd0) || (c == 4'd1) || (c == 4'd12);
		k.data_side  = (c >= 4'd4 && c <= 4'd7) || (c == 4'd13) || (c == 4'd15);
		k.page_fault = (c == 4'd12) || (c == 4'd13) || (c == 4'd15);
		k.illegal    = (c == 4'd2);
		k.ecall_sys  = (c == 4'd9) || (c == 4'd11);
		return k;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		errors++;
		$display("** Error: %s expected %h got %h at %0t", name, exp_v, act_v, $time);
	endtask

	task automatic check_registered();
		checks++;
		if (cmd !== exp_cmd)
			report_mismatch("cmd_o", 64'(exp_cmd), 64'(cmd));
		if (tlb_flush.kind !== exp_tlb.kind)
			report_mismatch("tlb_flush_o.kind", 64'(exp_tlb.kind), 64'(tlb_flush.kind));
		if (tlb_flush.asid !== exp_tlb.asid)
			report_mismatch("tlb_flush_o.asid", 64'(exp_tlb.asid), 64'(tlb_flush.asid));
		if (tlb_flush.vpn !== exp_tlb.vpn)
			report_mismatch("tlb_flush_o.vpn", 64'(exp_tlb.vpn), 64'(tlb_flush.vpn));
		if (flush !== exp_flush)
			report_mismatch("flush_o", 64'(exp_flush), 64'(flush));
		if (stall !== exp_stall)
			report_mismatch("stall_o", 64'(exp_stall), 64'(stall));
		if (synch !== (m_state == ctl_pkg::MS_SYNC))
			report_mismatch("synch_o", 64'(m_state == ctl_pkg::MS_SYNC), 64'(synch));
	endtask

	// Half from the legal pool, funct3 left random for branch/load/store
	task automatic gen_instr(output ctl_pkg::instr_t w);
		logic [31:0] r;
		logic [31:0] sel;
		int          kind;
		r    = $random(seed);
		sel  = $random(seed);
		kind = int'(sel[7:1]) % 5;
		w    = r;
		if (sel[0]) begin
			case (kind)
				0: w[6:0] = ctl_pkg::OPC_BRANCH;
				1: w[6:0] = ctl_pkg::OPC_LOAD;
				2: w[6:0] = ctl_pkg::OPC_STORE;
				3: begin
					w[6:0]   = ctl_pkg::OPC_MISC_MEM;
					w[14:12] = ctl_pkg::F3_FENCE_I;
				end
				default: begin
					w[6:0]   = ctl_pkg::OPC_SYSTEM;
					w[14:12] = ctl_pkg::F3_PRIV;
					w[31:25] = ctl_pkg::F7_SFENCE_VMA;
				end
			endcase
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		gen_instr(instr);
		r = $random(seed);
		instr_valid = (r % 32'd100) < 32'd60;
		r = $random(seed);
		main_stall = (r % 32'd100) < 32'd20;
		r = $random(seed);
		fetch_except = (r % 32'd100) < 32'd5;
		r = $random(seed);
		except_raised = (r % 32'd100) < 32'd5;
		r = $random(seed);
		except_code = ctl_pkg::except_code_e'(r[3:0]);
		asid = r[31:16];
		except_addr = {$random(seed), $random(seed)};
		// Completion comes 1 to 8 cycles after the sync starts
		r = $random(seed);
		if (m_state == ctl_pkg::MS_SYNC) begin
			if (!done_armed) begin
				done_armed = 1'b1;
				done_cnt   = 1 + int'(r[2:0]);
			end
			l2c_done = (done_cnt == 0);
			done_cnt--;
		end else begin
			done_armed = 1'b0;
			l2c_done   = (r[7:4] == 4'd0);
		end
	endtask

	task automatic compute_next();
		ctl_pkg::decode_t       d;
		ctl_pkg::except_class_t k;
		d         = expect_decode(instr);
		k         = classify_code(except_code);
		nxt_cmd   = '0;
		nxt_tlb   = '0;
		nxt_flush = 1'b0;
		nxt_stall = main_stall;
		nxt_state = m_state;
		if (m_state == ctl_pkg::MS_IDLE) begin
			if (except_raised) begin
				nxt_flush         = 1'b1;
				nxt_cmd.abort     = k.illegal;
				nxt_cmd.clr_l1tlb = k.instr_side;
				nxt_cmd.clr_l2tlb = k.instr_side;
				nxt_cmd.clr_dmshr = k.data_side;
				if (k.page_fault) begin
					nxt_tlb.kind = ctl_pkg::TLB_FLUSH_PAGE;
					nxt_tlb.vpn  = except_addr[38:12];
				end else begin
					nxt_tlb.kind = ctl_pkg::TLB_FLUSH_ALL;
				end
				if (k.ecall_sys) begin
					nxt_state = ctl_pkg::MS_SYNC;
					nxt_stall = 1'b1;
				end
			end else if (fetch_except) begin
				nxt_flush    = 1'b1;
				nxt_stall    = 1'b1;
				nxt_tlb.kind = ctl_pkg::TLB_FLUSH_ASID;
				nxt_tlb.asid = asid;
			end else if (instr_valid && d.fence_i) begin
				nxt_cmd.clr_l1tlb = 1'b1;
				nxt_cmd.clr_l2tlb = 1'b1;
			end else if (instr_valid && d.sfence_vma) begin
				nxt_cmd.clr_l1tlb = 1'b1;
				nxt_cmd.clr_l2tlb = 1'b1;
				nxt_cmd.clr_dmshr = 1'b1;
				nxt_tlb.kind      = ctl_pkg::TLB_FLUSH_ALL;
				nxt_state         = ctl_pkg::MS_SYNC;
				nxt_stall         = 1'b1;
			end
		end else if (l2c_done) begin
			nxt_state = ctl_pkg::MS_IDLE;
		end else begin
			nxt_stall = 1'b1;
		end
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		instr         = '0;
		instr_valid   = 1'b0;
		main_stall    = 1'b0;
		fetch_except  = 1'b0;
		except_raised = 1'b0;
		except_code   = ctl_pkg::E_I_ADDR_MISALIGNED;
		except_addr   = '0;
		asid          = '0;
		l2c_done      = 1'b0;
		errors        = 0;
		checks        = 0;
		done_armed    = 1'b0;
		done_cnt      = 0;
		m_state       = ctl_pkg::MS_IDLE;
		exp_cmd       = '0;
		exp_tlb       = '0;
		exp_flush     = 1'b0;
		exp_stall     = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Outputs straight out of reset
		check_registered();
		compute_next();

		repeat (CYCLES) begin
			@(posedge clk);
			#1;
			m_state   = nxt_state;
			exp_cmd   = nxt_cmd;
			exp_tlb   = nxt_tlb;
			exp_flush = nxt_flush;
			exp_stall = nxt_stall;
			check_registered();
			drive_inputs();
			#1;
			checks++;
			if (dec !== expect_decode(instr))
				report_mismatch("dec_o", 64'(expect_decode(instr)), 64'(dec));
			compute_next();
		end

		$display("Summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule

//--- compile.f
src/ctl_pkg.sv
src/ctl_instr_decode.sv
src/ctl_except_classify.sv
src/ctl_maint_fsm.sv
src/ctl_unit_top.sv
testbench/tb_ctl_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
	--top-module tb_ctl_unit -Mdir obj_dir -o sim_ctl_unit

# Keep the log even when the simulation exits with an error
./obj_dir/sim_ctl_unit > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "No errors" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
